//--- Bender.yml
package:
  name: ddr_read_arbiter

sources:
  - logic/rd_port_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/rd_port_arbiter.sv
  - logic/burst_expander.sv
  - logic/route_fifo.sv
  - logic/line_assembler.sv
  - logic/ddr_read_arbiter.sv
  - target: simulation
    files:
      - dv/ddr_mem_model.sv
      - dv/ddr_read_arbiter_tb.sv

//--- compile.f
logic/rd_port_pkg.sv
logic/mem_bus_pkg.sv
logic/rd_port_arbiter.sv
logic/burst_expander.sv
logic/route_fifo.sv
logic/line_assembler.sv
logic/ddr_read_arbiter.sv
dv/ddr_mem_model.sv
dv/ddr_read_arbiter_tb.sv

//--- dv/ddr_mem_model.sv
`timescale 1ns/1ps

module ddr_mem_model (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  mem_bus_pkg::mem_req_t  ar_i,
    input  logic                   ar_vld_i,
    output logic                   ar_rdy_o,
    output mem_bus_pkg::mem_beat_t r_beat_o,
    output logic                   r_vld_o,
    input  logic                   r_rdy_i
);
    import rd_port_pkg::*;
    import mem_bus_pkg::*;

    // lines accepted and not yet fully returned
    logic [LINE_ADDR_W-1:0] pend_q [$];
    int                     beat_idx;
    logic                   r_xfer;

    // beat k of line a, line address above the beat index
    function automatic mem_beat_t beat_value(input logic [LINE_ADDR_W-1:0] addr, input int k);
        return {(BEAT_W-32)'(addr), 32'(k)};
    endfunction

    initial
    begin
        ar_rdy_o = 1'b0;
        r_vld_o  = 1'b0;
        r_beat_o = '0;
        beat_idx = 0;
        r_xfer   = 1'b0;
    end

    always @(posedge clk_i)
    begin
        r_xfer = 1'b0;
        if (!rst_i)
        begin
            // accepted request, keep only the line address
            if (ar_vld_i && ar_rdy_o)
            begin
                pend_q.push_back(ar_i.byte_addr[BYTE_ADDR_W-1:LINE_OFFSET_W]);
            end
            if (r_vld_o && r_rdy_i)
            begin
                r_xfer = 1'b1;
                if (beat_idx == BEATS_PER_LINE - 1)
                begin
                    beat_idx = 0;
                    void'(pend_q.pop_front());
                end
                else
                begin
                    beat_idx++;
                end
            end
        end
        #1;
        // roughly one stall in four on both channels
        ar_rdy_o = !rst_i && ($urandom_range(3) != 0);
        // a beat on offer stays until taken
        if (!r_vld_o || r_xfer)
        begin
            r_vld_o = !rst_i && (pend_q.size() > 0) && ($urandom_range(3) != 0);
            if (r_vld_o)
            begin
                r_beat_o = beat_value(pend_q[0], beat_idx);
            end
        end
    end

endmodule

//--- dv/ddr_read_arbiter_tb.sv
`timescale 1ns/1ps

module ddr_read_arbiter_tb;
    import rd_port_pkg::*;
    import mem_bus_pkg::*;

    // commands per port in each test
    localparam int RR_CMDS    = 4;
    localparam int STALL_CMDS = 6;

    logic                             clk_i;
    logic                             rst_i;
    rd_cmd_t [NUM_PORTS-1:0]          cmd_i;
    port_sel_t                        cmd_vld_i;
    port_sel_t                        cmd_rdy_o;
    logic [NUM_PORTS-1:0][LINE_W-1:0] rdata_o;
    port_sel_t                        rdata_vld_o;
    port_sel_t                        rdata_last_o;
    port_sel_t                        rdata_rdy_i;
    mem_req_t                         ar_o;
    logic                             ar_vld_o;
    logic                             ar_rdy_i;
    mem_beat_t                        r_beat_i;
    logic                             r_vld_i;
    logic                             r_rdy_o;

    // ==============================
    // scoreboard state
    // ==============================

    string                            test_name;
    bit                               rr_mode;
    bit                               stall_mode;
    bit                               stim_done;
    rd_cmd_t                          cmd_list [NUM_PORTS][$];
    logic [LINE_ADDR_W-1:0]           exp_req_q [$];
    logic [LINE_ADDR_W-1:0]           exp_line_q [NUM_PORTS][$];
    bit                               exp_last_q [NUM_PORTS][$];
    // queue heads sampled by the assertions
    logic [BYTE_ADDR_W-1:0]           exp_ar_addr;
    bit                               exp_ar_pend;
    logic [NUM_PORTS-1:0][LINE_W-1:0] exp_line;
    port_sel_t                        exp_last;
    port_sel_t                        exp_line_pend;
    port_sel_t                        prev_acc;
    int                               req_errors;
    int                               line_errors;
    int                               last_errors;
    int                               proto_errors;
    int                               total_lines;
    int                               cycle_cnt;
    int                               timeout_limit;

    ddr_read_arbiter u_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .cmd_vld_i    (cmd_vld_i),
        .cmd_rdy_o    (cmd_rdy_o),
        .rdata_o      (rdata_o),
        .rdata_vld_o  (rdata_vld_o),
        .rdata_last_o (rdata_last_o),
        .rdata_rdy_i  (rdata_rdy_i),
        .ar_o         (ar_o),
        .ar_vld_o     (ar_vld_o),
        .ar_rdy_i     (ar_rdy_i),
        .r_beat_i     (r_beat_i),
        .r_vld_i      (r_vld_i),
        .r_rdy_o      (r_rdy_o)
    );

    ddr_mem_model u_mem (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ar_i     (ar_o),
        .ar_vld_i (ar_vld_o),
        .ar_rdy_o (ar_rdy_i),
        .r_beat_o (r_beat_i),
        .r_vld_o  (r_vld_i),
        .r_rdy_i  (r_rdy_o)
    );

    always #5 clk_i = ~clk_i;

    // four patterned beats with beat k in slice k
    function automatic logic [LINE_W-1:0] expected_line(input logic [LINE_ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        line = '0;
        for (int k = 0; k < BEATS_PER_LINE; k++)
        begin
            line[k*BEAT_W +: BEAT_W] = {(BEAT_W-32)'(addr), 32'(k)};
        end
        return line;
    endfunction

    function automatic bit drained();
        bit empty;
        empty = stim_done && (exp_req_q.size() == 0);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (exp_line_q[p].size() != 0)
            begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic build_cmds(input int count, input int max_len);
        rd_cmd_t cmd;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            for (int n = 0; n < count; n++)
            begin
                cmd.line_addr = LINE_ADDR_W'($urandom_range(20'hf_ffff));
                cmd.burst_len = BURST_LEN_W'($urandom_range(max_len));
                cmd_list[p].push_back(cmd);
                total_lines += int'(cmd.burst_len) + 1;
            end
        end
    endtask

    // entered and left 1 ns after an edge
    task automatic issue_cmds(input int p, input int count, input bit gaps);
        rd_cmd_t cmd;
        for (int n = 0; n < count; n++)
        begin
            cmd = cmd_list[p].pop_front();
            if (gaps)
            begin
                cmd_vld_i[p] = 1'b0;
                repeat ($urandom_range(3))
                begin
                    @(posedge clk_i);
                    #1;
                end
            end
            cmd_i[p]     = cmd;
            cmd_vld_i[p] = 1'b1;
            @(posedge clk_i);
            while (!cmd_rdy_o[p])
            begin
                @(posedge clk_i);
            end
            #1;
        end
        cmd_vld_i[p] = 1'b0;
    endtask

    // ==============================
    // monitor
    // ==============================

    always @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            // one request and one line per beat-line of each accepted burst
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (cmd_vld_i[p] && cmd_rdy_o[p])
                begin
                    prev_acc = port_sel_t'(1 << p);
                    for (int i = 0; i <= int'(cmd_i[p].burst_len); i++)
                    begin
                        exp_req_q.push_back(cmd_i[p].line_addr + LINE_ADDR_W'(i));
                        exp_line_q[p].push_back(cmd_i[p].line_addr + LINE_ADDR_W'(i));
                        exp_last_q[p].push_back(i == int'(cmd_i[p].burst_len));
                    end
                end
            end
            if (ar_vld_o && ar_rdy_i && (exp_req_q.size() > 0))
            begin
                void'(exp_req_q.pop_front());
            end
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (rdata_vld_o[p] && rdata_rdy_i[p] && (exp_line_q[p].size() > 0))
                begin
                    void'(exp_line_q[p].pop_front());
                    void'(exp_last_q[p].pop_front());
                end
            end
        end
        // refresh heads for the next edge
        exp_ar_pend = (exp_req_q.size() > 0);
        if (exp_ar_pend)
        begin
            // 64 bytes per line
            exp_ar_addr = BYTE_ADDR_W'(exp_req_q[0]) * 64;
        end
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            exp_line_pend[p] = (exp_line_q[p].size() > 0);
            if (exp_line_pend[p])
            begin
                exp_line[p] = expected_line(exp_line_q[p][0]);
                exp_last[p] = exp_last_q[p][0];
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    a_reset_idle: assert property (@(posedge clk_i)
        (rst_i || $fell(rst_i)) |-> (cmd_rdy_o == '0) && !ar_vld_o && !r_rdy_o
                                     && (rdata_vld_o == '0))
        else
        begin
            $display("handshake output high during or right after reset");
            proto_errors++;
        end

    a_rdy_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(cmd_rdy_o))
        else
        begin
            $display("command ready high toward both ports");
            proto_errors++;
        end

    a_vld_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(rdata_vld_o))
        else
        begin
            $display("line valid high toward both ports");
            proto_errors++;
        end

    // both ports busy so the grant must swap sides
    a_rr_alternate: assert property (@(posedge clk_i) disable iff (rst_i)
        rr_mode && ((cmd_vld_i & cmd_rdy_o) != '0) && (prev_acc != '0)
        |-> ((cmd_vld_i & cmd_rdy_o) != prev_acc))
        else
        begin
            $display("[ERROR] %s: accepted port expected %b actual %b", test_name,
                     ~$sampled(prev_acc), $sampled(cmd_vld_i & cmd_rdy_o));
            proto_errors++;
        end

    a_req_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        ar_vld_o && ar_rdy_i |-> exp_ar_pend)
        else
        begin
            $display("memory request issued with no line outstanding");
            req_errors++;
        end

    a_req_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        ar_vld_o && ar_rdy_i && exp_ar_pend |-> (ar_o.byte_addr == exp_ar_addr))
        else
        begin
            $display("[ERROR] %s: request address expected %h actual %h", test_name,
                     $sampled(exp_ar_addr), $sampled(ar_o.byte_addr));
            req_errors++;
        end

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port_chk
        a_line_expected: assert property (@(posedge clk_i) disable iff (rst_i)
            rdata_vld_o[p] && rdata_rdy_i[p] |-> exp_line_pend[p])
            else
            begin
                $display("line returned to port %0d with nothing outstanding", p);
                line_errors++;
            end

        a_line_data: assert property (@(posedge clk_i) disable iff (rst_i)
            rdata_vld_o[p] && rdata_rdy_i[p] && exp_line_pend[p] |-> (rdata_o[p] == exp_line[p]))
            else
            begin
                $display("[ERROR] %s: port %0d line expected %h actual %h", test_name, p,
                         $sampled(exp_line[p]), $sampled(rdata_o[p]));
                line_errors++;
            end

        a_line_last: assert property (@(posedge clk_i) disable iff (rst_i)
            rdata_vld_o[p] && rdata_rdy_i[p] && exp_line_pend[p]
            |-> (rdata_last_o[p] == exp_last[p]))
            else
            begin
                $display("[ERROR] %s: port %0d last expected %b actual %b", test_name, p,
                         $sampled(exp_last[p]), $sampled(rdata_last_o[p]));
                last_errors++;
            end
    end

    // ==============================
    // stimulus
    // ==============================

    // client ready is random per port in the stall test
    always @(posedge clk_i)
    begin
        #1;
        rdata_rdy_i = stall_mode ? port_sel_t'($urandom_range(3)) : '1;
    end

    initial
    begin : watchdog
        @(posedge clk_i);
        while (cycle_cnt < timeout_limit)
        begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: lines still outstanding after %0d cycles", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h482b_12d2));
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        cmd_i         = '0;
        cmd_vld_i     = '0;
        rdata_rdy_i   = '0;
        test_name     = "reset";
        rr_mode       = 1'b0;
        stall_mode    = 1'b0;
        stim_done     = 1'b0;
        exp_ar_addr   = '0;
        exp_ar_pend   = 1'b0;
        exp_line      = '0;
        exp_last      = '0;
        exp_line_pend = '0;
        prev_acc      = '0;
        req_errors    = 0;
        line_errors   = 0;
        last_errors   = 0;
        proto_errors  = 0;
        total_lines   = 0;
        cycle_cnt     = 0;
        build_cmds(RR_CMDS, 3);
        build_cmds(STALL_CMDS, 5);
        timeout_limit = 40 * total_lines + 200;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // clients stay idle for the first cycle out of reset
        @(posedge clk_i);
        #1;

        // both ports valid back to back
        test_name = "rr_alternate";
        rr_mode   = 1'b1;
        fork
            issue_cmds(0, RR_CMDS, 1'b0);
            issue_cmds(1, RR_CMDS, 1'b0);
        join
        rr_mode = 1'b0;

        // idle gaps plus client and memory stalls
        test_name  = "random_stall";
        stall_mode = 1'b1;
        fork
            issue_cmds(0, STALL_CMDS, 1'b1);
            issue_cmds(1, STALL_CMDS, 1'b1);
        join
        stim_done = 1'b1;

        while (!drained())
        begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        $display("errors: request %0d, line %0d, last %0d, protocol %0d",
                 req_errors, line_errors, last_errors, proto_errors);
        if (req_errors + line_errors + last_errors + proto_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- logic/burst_expander.sv
`timescale 1ns/1ps

module burst_expander (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  rd_port_pkg::rd_cmd_t   cmd_i,
    output logic                   busy_o,
    output mem_bus_pkg::mem_req_t  ar_o,
    output logic                   ar_vld_o,
    input  logic                   ar_rdy_i
);
    import rd_port_pkg::*;
    import mem_bus_pkg::*;

    logic                   busy_q;
    logic [LINE_ADDR_W-1:0] cur_q;
    logic [LINE_ADDR_W-1:0] last_q;
    logic [LINE_ADDR_W-1:0] cur_addr;
    logic [LINE_ADDR_W-1:0] last_addr;
    logic                   active;
    logic                   ar_xfer;
    logic                   at_last;

    // ==============================
    // current request
    // ==============================

    // first line goes out in the start cycle itself
    assign active    = busy_q || start_i;
    assign cur_addr  = start_i ? cmd_i.line_addr : cur_q;
    assign last_addr = start_i ? cmd_i.line_addr + LINE_ADDR_W'(cmd_i.burst_len) : last_q;
    assign at_last   = (cur_addr == last_addr);

    assign ar_vld_o       = active;
    assign ar_o.byte_addr = {cur_addr, {LINE_OFFSET_W{1'b0}}};
    assign ar_xfer        = ar_vld_o && ar_rdy_i;

    // busy covers the start cycle so no second grant slips in
    assign busy_o = active;

    // ==============================
    // line stepping
    // ==============================

    // drops after the final line transfers
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            busy_q <= 1'b0;
        end
        else if (active)
        begin
            busy_q <= !(ar_xfer && at_last);
        end
    end

    // hold address while memory stalls, step by one line per transfer
    always_ff @(posedge clk_i)
    begin
        if (active)
        begin
            cur_q  <= ar_xfer ? cur_addr + 1'b1 : cur_addr;
            last_q <= last_addr;
        end
    end

    // arbiter must hold off while a burst is still expanding
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> !busy_q)
        else $error("burst start while expander busy");

endmodule

//--- logic/ddr_read_arbiter.sv
`timescale 1ns/1ps

module ddr_read_arbiter (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    // client command side
    input  rd_port_pkg::rd_cmd_t [rd_port_pkg::NUM_PORTS-1:0]         cmd_i,
    input  rd_port_pkg::port_sel_t                                    cmd_vld_i,
    output rd_port_pkg::port_sel_t                                    cmd_rdy_o,
    // client data side
    output logic [rd_port_pkg::NUM_PORTS-1:0][rd_port_pkg::LINE_W-1:0] rdata_o,
    output rd_port_pkg::port_sel_t                                    rdata_vld_o,
    output rd_port_pkg::port_sel_t                                    rdata_last_o,
    input  rd_port_pkg::port_sel_t                                    rdata_rdy_i,
    // memory side
    output mem_bus_pkg::mem_req_t                                     ar_o,
    output logic                                                      ar_vld_o,
    input  logic                                                      ar_rdy_i,
    input  mem_bus_pkg::mem_beat_t                                    r_beat_i,
    input  logic                                                      r_vld_i,
    output logic                                                      r_rdy_o
);

    // ==============================
    // internal wiring
    // ==============================

    logic                     grant;
    rd_port_pkg::rd_cmd_t     grant_cmd;
    rd_port_pkg::port_sel_t   grant_sel;
    rd_port_pkg::route_rec_t  push_rec;
    logic                     route_full;
    logic                     exp_busy;
    rd_port_pkg::route_rec_t  head_rec;
    logic                     head_vld;
    logic                     route_pop;

    // owner and length of the granted burst
    assign push_rec = '{sel: grant_sel, burst_len: grant_cmd.burst_len};

    rd_port_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .cmd_vld_i    (cmd_vld_i),
        .cmd_rdy_o    (cmd_rdy_o),
        .route_full_i (route_full),
        .exp_busy_i   (exp_busy),
        .grant_o      (grant),
        .grant_cmd_o  (grant_cmd),
        .grant_sel_o  (grant_sel)
    );

    burst_expander u_expander (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (grant),
        .cmd_i    (grant_cmd),
        .busy_o   (exp_busy),
        .ar_o     (ar_o),
        .ar_vld_o (ar_vld_o),
        .ar_rdy_i (ar_rdy_i)
    );

    route_fifo u_route (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (grant),
        .rec_i       (push_rec),
        .full_o      (route_full),
        .pop_i       (route_pop),
        .head_o      (head_rec),
        .not_empty_o (head_vld)
    );

    line_assembler u_assembler (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .beat_i      (r_beat_i),
        .r_vld_i     (r_vld_i),
        .r_rdy_o     (r_rdy_o),
        .head_i      (head_rec),
        .head_vld_i  (head_vld),
        .pop_o       (route_pop),
        .line_o      (rdata_o),
        .line_vld_o  (rdata_vld_o),
        .line_last_o (rdata_last_o),
        .line_rdy_i  (rdata_rdy_i)
    );

endmodule

//--- logic/line_assembler.sv
`timescale 1ns/1ps

module line_assembler (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    input  mem_bus_pkg::mem_beat_t                                    beat_i,
    input  logic                                                      r_vld_i,
    output logic                                                      r_rdy_o,
    input  rd_port_pkg::route_rec_t                                   head_i,
    input  logic                                                      head_vld_i,
    output logic                                                      pop_o,
    output logic [rd_port_pkg::NUM_PORTS-1:0][rd_port_pkg::LINE_W-1:0] line_o,
    output rd_port_pkg::port_sel_t                                    line_vld_o,
    output rd_port_pkg::port_sel_t                                    line_last_o,
    input  rd_port_pkg::port_sel_t                                    line_rdy_i
);
    import rd_port_pkg::*;
    import mem_bus_pkg::*;

    // beat buffer
    mem_beat_t                         bb_mem [BEAT_BUF_DEPTH];
    logic [$clog2(BEAT_BUF_DEPTH):0]   bb_wr;
    logic [$clog2(BEAT_BUF_DEPTH):0]   bb_rd;
    logic [$clog2(BEAT_BUF_DEPTH):0]   bb_cnt;
    logic [$clog2(BEAT_BUF_DEPTH):0]   bb_cnt_nxt;
    logic                              bb_push;
    logic                              bb_pop;
    logic                              rdy_q;

    // line build and return
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
    logic                              beat_last;
    logic [LINE_W-1:0]                 line_q;
    logic                              line_full_q;
    logic                              first_q;
    logic [BURST_LEN_W-1:0]            rem_q;
    logic [BURST_LEN_W-1:0]            rem;
    logic                              offer;
    logic                              accept;

    // ==============================
    // beat buffer
    // ==============================

    assign bb_push    = r_vld_i && r_rdy_o;
    assign bb_cnt     = bb_wr - bb_rd;
    assign bb_cnt_nxt = bb_cnt + bb_push - bb_pop;

    // registered ready, low out of reset, drops when the next beat has no slot
    assign r_rdy_o = rdy_q;

    always_ff @(posedge clk_i)
    begin
        if (bb_push)
        begin
            bb_mem[bb_wr[$clog2(BEAT_BUF_DEPTH)-1:0]] <= beat_i;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            bb_wr <= '0;
            bb_rd <= '0;
            rdy_q <= 1'b0;
        end
        else
        begin
            bb_wr <= bb_wr + bb_push;
            bb_rd <= bb_rd + bb_pop;
            rdy_q <= (int'(bb_cnt_nxt) < BEAT_BUF_DEPTH);
        end
    end

    // ==============================
    // line build
    // ==============================

    // pull a beat unless a finished line is still waiting
    assign bb_pop    = (bb_wr != bb_rd) && (!line_full_q || accept);
    assign beat_last = (int'(beat_cnt) == BEATS_PER_LINE - 1);

    // shift in from the top, beat k lands in slice k after the fourth
    always_ff @(posedge clk_i)
    begin
        if (bb_pop)
        begin
            line_q <= {bb_mem[bb_rd[$clog2(BEAT_BUF_DEPTH)-1:0]], line_q[LINE_W-1:BEAT_W]};
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            beat_cnt    <= '0;
            line_full_q <= 1'b0;
        end
        else
        begin
            if (bb_pop)
            begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            end
            if (bb_pop && beat_last)
            begin
                line_full_q <= 1'b1;
            end
            else if (accept)
            begin
                line_full_q <= 1'b0;
            end
        end
    end

    // ==============================
    // routing to the client
    // ==============================

    // head burst_len counts lines left after this one
    assign rem    = first_q ? head_i.burst_len : rem_q;
    assign offer  = line_full_q && head_vld_i;
    assign accept = |(line_vld_o & line_rdy_i);
    assign pop_o  = accept && (rem == '0);

    assign line_vld_o  = head_i.sel & {NUM_PORTS{offer}};
    assign line_last_o = head_i.sel & {NUM_PORTS{offer && (rem == '0)}};

    // same line toward every port, valid picks the owner
    always_comb
    begin
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            line_o[p] = line_q;
        end
    end

    // next line after the last one starts a new record
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            first_q <= 1'b1;
        end
        else if (accept)
        begin
            first_q <= (rem == '0);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            rem_q <= rem - 1'b1;
        end
    end

    // route records carry a one-hot select
    a_vld_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(line_vld_o))
        else $error("line valid toward more than one port");

endmodule

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

    // ==============================
    // memory side geometry
    // ==============================

    // width of one return beat
    localparam int BEAT_W = 128;

    // beats that make up one client line
    localparam int BEATS_PER_LINE = rd_port_pkg::LINE_W / BEAT_W;

    // byte address toward the memory
    localparam int BYTE_ADDR_W = 32;

    // 64 bytes per line
    localparam int LINE_OFFSET_W = 6;

    // ==============================
    // internal buffer depths
    // ==============================

    // bursts in flight between command and return side
    localparam int ROUTE_DEPTH = 8;

    // beats parked while a line waits for its client
    localparam int BEAT_BUF_DEPTH = 8;

    // one read request, single line
    typedef struct packed {
        logic [BYTE_ADDR_W-1:0] byte_addr;
    } mem_req_t;

    // one return beat
    typedef logic [BEAT_W-1:0] mem_beat_t;

endpackage

//--- logic/rd_port_arbiter.sv
`timescale 1ns/1ps

module rd_port_arbiter (
    input  logic                                               clk_i,
    input  logic                                               rst_i,
    input  rd_port_pkg::rd_cmd_t [rd_port_pkg::NUM_PORTS-1:0]  cmd_i,
    input  rd_port_pkg::port_sel_t                             cmd_vld_i,
    output rd_port_pkg::port_sel_t                             cmd_rdy_o,
    input  logic                                               route_full_i,
    input  logic                                               exp_busy_i,
    output logic                                               grant_o,
    output rd_port_pkg::rd_cmd_t                               grant_cmd_o,
    output rd_port_pkg::port_sel_t                             grant_sel_o
);
    import rd_port_pkg::*;

    // one-hot round-robin pointer
    port_sel_t rr_ptr;
    logic      fav_vld;
    logic      can_accept;
    logic      accept;
    rd_cmd_t   fav_cmd;

    // favored port has something to send
    assign fav_vld = |(rr_ptr & cmd_vld_i);

    // expander idle and room to record the route
    assign can_accept = !exp_busy_i && !route_full_i;

    // ready only toward the favored port and only when it is asking
    assign cmd_rdy_o = rr_ptr & cmd_vld_i & {NUM_PORTS{can_accept}};
    assign accept    = |(cmd_rdy_o & cmd_vld_i);

    // command of the favored port
    always_comb
    begin
        fav_cmd = '0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (rr_ptr[p])
            begin
                fav_cmd = cmd_i[p];
            end
        end
    end

    // rotate after a grant, or skip over an idle port
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rr_ptr  <= port_sel_t'(1);
            grant_o <= 1'b0;
        end
        else
        begin
            grant_o <= accept;
            if (accept || !fav_vld)
            begin
                rr_ptr <= {rr_ptr[NUM_PORTS-2:0], rr_ptr[NUM_PORTS-1]};
            end
        end
    end

    // accepted command, valid together with grant_o
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            grant_cmd_o <= fav_cmd;
            grant_sel_o <= rr_ptr;
        end
    end

    // pointer stays one-hot, so at most one client may see ready
    a_rdy_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(cmd_rdy_o))
        else $error("cmd_rdy_o high for more than one port");

endmodule

//--- logic/rd_port_pkg.sv
package rd_port_pkg;

    // ==============================
    // client port geometry
    // ==============================

    // two read clients, the round-robin logic assumes this
    localparam int NUM_PORTS = 2;

    // address in units of one 512-bit line
    localparam int LINE_ADDR_W = 26;

    // burst length, L means L+1 lines
    localparam int BURST_LEN_W = 16;

    // one returned line
    localparam int LINE_W = 512;

    // ==============================
    // client records
    // ==============================

    // one bit per client, at most one set
    typedef logic [NUM_PORTS-1:0] port_sel_t;

    // burst command as issued by a client
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [BURST_LEN_W-1:0] burst_len;
    } rd_cmd_t;

    // return routing of one accepted burst
    // sel picks the client, burst_len counts the lines still owed
    typedef struct packed {
        port_sel_t              sel;
        logic [BURST_LEN_W-1:0] burst_len;
    } route_rec_t;

endpackage

//--- logic/route_fifo.sv
`timescale 1ns/1ps

module route_fifo (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     push_i,
    input  rd_port_pkg::route_rec_t  rec_i,
    output logic                     full_o,
    input  logic                     pop_i,
    output rd_port_pkg::route_rec_t  head_o,
    output logic                     not_empty_o
);
    import rd_port_pkg::*;
    import mem_bus_pkg::*;

    // one extra pointer bit tells full from empty
    logic [$clog2(ROUTE_DEPTH):0]   wr_ptr;
    logic [$clog2(ROUTE_DEPTH):0]   rd_ptr;
    route_rec_t                     rec_mem [ROUTE_DEPTH];

    // record storage
    always_ff @(posedge clk_i)
    begin
        if (push_i)
        begin
            rec_mem[wr_ptr[$clog2(ROUTE_DEPTH)-1:0]] <= rec_i;
        end
    end

    // pointers
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push_i)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head read straight from storage, new record shows next cycle
    assign head_o      = rec_mem[rd_ptr[$clog2(ROUTE_DEPTH)-1:0]];
    assign not_empty_o = (wr_ptr != rd_ptr);
    assign full_o      = (wr_ptr[$clog2(ROUTE_DEPTH)] != rd_ptr[$clog2(ROUTE_DEPTH)])
                      && (wr_ptr[$clog2(ROUTE_DEPTH)-1:0] == rd_ptr[$clog2(ROUTE_DEPTH)-1:0]);

    // arbiter gates on full, assembler pops only a live record
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o)
        else $error("route record pushed while full");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> not_empty_o)
        else $error("route record popped while empty");

endmodule
